//--- include/sd_defines.svh
`ifndef SD_DEFINES_SVH
`define SD_DEFINES_SVH

`define SD_FRAME_BITS 48      // start + dir + index + arg + crc7 + end
`define SD_ARG_BITS 32
`define SD_ADDR_W 4

// register map with the arg bytes at 0..3
`define SD_REG_CMD 4'd4       // write launches a command
`define SD_REG_RESP_ARG 4'd5  // response bytes 5..8 with the lsb first
`define SD_REG_RESP_IDX 4'd9
`define SD_REG_STATUS 4'd10

`endif

//--- rtl/sd_cmd_host.sv
`include "sd_defines.svh"

module sd_cmd_host (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_cs,
    input  logic [`SD_ADDR_W-1:0] i_addr,
    input  logic [7:0]            i_wdata,
    output logic [7:0]            o_rdata,
    input  logic                  i_sd_cmd,
    output logic                  o_sd_cmd,
    input  logic                  i_sd_dat,
    output logic                  o_sd_dat
);

    logic                    grant_tx;
    logic                    line_free;
    logic                    rx_claim;
    logic                    rx_release;
    logic                    resp_strobe;
    logic [5:0]              resp_index;
    logic [`SD_ARG_BITS-1:0] resp_arg;
    logic                    resp_crc_ok;

    sd_cmd_if cmd_bus ();

    sd_host_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .i_cs          (i_cs),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .o_rdata       (o_rdata),
        .cmd           (cmd_bus.regs),
        .i_resp_strobe (resp_strobe),
        .i_resp_index  (resp_index),
        .i_resp_arg    (resp_arg),
        .i_resp_crc_ok (resp_crc_ok)
    );

    sd_line_arbiter u_arb (
        .clk           (clk),
        .rst           (rst),
        .i_cmd_pending (cmd_bus.cmd_pending),
        .i_tx_done     (cmd_bus.tx_done),
        .i_rx_claim    (rx_claim),
        .i_rx_release  (rx_release),
        .o_grant_tx    (grant_tx),
        .o_line_free   (line_free)
    );

    sd_cmd_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd_bus.tx),
        .i_grant   (grant_tx),
        .o_cmd_bit (o_sd_cmd)
    );

    sd_resp_rx u_rx (
        .clk           (clk),
        .rst           (rst),
        .i_line_free   (line_free),
        .i_cmd_bit     (i_sd_cmd),
        .o_claim       (rx_claim),
        .o_release     (rx_release),
        .o_resp_strobe (resp_strobe),
        .o_resp_index  (resp_index),
        .o_resp_arg    (resp_arg),
        .o_resp_crc_ok (resp_crc_ok)
    );

    assign o_sd_dat = 1'b1;  // no data path so i_sd_dat is ignored

endmodule

//--- rtl/sd_cmd_if.sv
`include "sd_defines.svh"

interface sd_cmd_if;

    logic cmd_pending;                 // held until tx_done
    logic [5:0] cmd_index;
    logic [`SD_ARG_BITS-1:0] cmd_arg;
    logic tx_done;                     // one-cycle pulse with the last bit

    modport regs (
        output cmd_pending,
        output cmd_index,
        output cmd_arg,
        input  tx_done
    );

    modport tx (
        input  cmd_pending,
        input  cmd_index,
        input  cmd_arg,
        output tx_done
    );

endinterface

//--- rtl/sd_cmd_tx.sv
`include "sd_defines.svh"

module sd_cmd_tx import sd_pkg::*; (
    input  logic clk,
    input  logic rst,
    sd_cmd_if.tx cmd,
    input  logic i_grant,
    output logic o_cmd_bit
);

    localparam logic [5:0] LAST_BIT = 6'(`SD_FRAME_BITS - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_CRC, TX_SHIFT} tx_state_t;

    tx_state_t  state;
    logic [5:0] bit_cnt;
    sd_frame_t  frame;
    logic       crc_load;
    logic [6:0] crc;
    logic       crc_valid;

    always_comb begin
        frame.start = 1'b0;
        frame.dir   = 1'b1;
        frame.index = cmd.cmd_index;
        frame.arg   = cmd.cmd_arg;
        frame.crc   = crc;
        frame.stop  = 1'b1;
    end

    sd_crc7 u_crc7 (
        .clk     (clk),
        .rst     (rst),
        .i_load  (crc_load),
        .i_data  ({frame.start, frame.dir, frame.index, frame.arg}),
        .o_crc   (crc),
        .o_valid (crc_valid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (i_grant && cmd.cmd_pending) begin
                        state <= TX_CRC;
                    end
                end
                TX_CRC: begin
                    state   <= TX_SHIFT;
                    bit_cnt <= '0;
                end
                TX_SHIFT: begin
                    if (crc_valid) begin                // crc lands one cycle after load
                        if (bit_cnt == LAST_BIT) begin
                            state   <= TX_IDLE;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 6'd1;
                        end
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    assign crc_load    = (state == TX_CRC);
    assign cmd.tx_done = (state == TX_SHIFT) && crc_valid && (bit_cnt == LAST_BIT);
    assign o_cmd_bit   = (state == TX_SHIFT) ? frame[LAST_BIT - bit_cnt] : 1'b1;  // idle high

endmodule

//--- rtl/sd_crc7.sv
`include "sd_defines.svh"

module sd_crc7 (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_load,
    input  logic [`SD_FRAME_BITS-9:0]   i_data,
    output logic [6:0]                  o_crc,
    output logic                        o_valid
);

    logic [6:0] crc_next;
    logic       valid_q;

    // serial x^7 + x^3 + 1 unrolled over the whole head
    always_comb begin
        logic fb;
        crc_next = '0;
        for (int i = `SD_FRAME_BITS - 9; i >= 0; i--) begin
            fb = i_data[i] ^ crc_next[6];
            crc_next = {crc_next[5:0], 1'b0};
            if (fb) begin
                crc_next = crc_next ^ 7'h09;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (i_load) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            o_crc <= crc_next;
        end
    end

    assign o_valid = valid_q & ~i_load;  // stale while a new head loads

endmodule

//--- rtl/sd_host_regs.sv
`include "sd_defines.svh"

module sd_host_regs import sd_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_cs,
    input  logic [`SD_ADDR_W-1:0]   i_addr,
    input  logic [7:0]              i_wdata,
    output logic [7:0]              o_rdata,
    sd_cmd_if.regs                  cmd,
    input  logic                    i_resp_strobe,
    input  logic [5:0]              i_resp_index,
    input  logic [`SD_ARG_BITS-1:0] i_resp_arg,
    input  logic                    i_resp_crc_ok
);

    logic [`SD_ARG_BITS-1:0] arg_q;
    logic [5:0]              index_q;
    logic [`SD_ARG_BITS-1:0] resp_arg_q;
    logic [5:0]              resp_idx_q;
    sd_status_t              status;
    logic                    wr_ok;
    logic                    cmd_write;
    logic [`SD_ADDR_W-1:0]   resp_sel;

    assign wr_ok     = i_cs & ~status.busy;  // frame contents frozen while busy
    assign cmd_write = wr_ok && (i_addr == `SD_REG_CMD);
    assign resp_sel  = i_addr - `SD_REG_RESP_ARG;

    always_ff @(posedge clk) begin
        if (wr_ok && (i_addr < `SD_REG_CMD)) begin
            arg_q[8*i_addr[1:0] +: 8] <= i_wdata;
        end
        if (cmd_write) begin
            index_q <= i_wdata[5:0];
        end
        if (i_resp_strobe) begin
            resp_arg_q <= i_resp_arg;
            resp_idx_q <= i_resp_index;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else begin
            if (cmd_write) begin
                status.busy       <= 1'b1;
                status.resp_valid <= 1'b0;
                status.crc_error  <= 1'b0;
            end else if (cmd.tx_done) begin
                status.busy <= 1'b0;
            end
            if (i_resp_strobe) begin
                status.resp_valid <= 1'b1;
                status.crc_error  <= ~i_resp_crc_ok;
            end
        end
    end

    assign cmd.cmd_pending = status.busy;
    assign cmd.cmd_index   = index_q;
    assign cmd.cmd_arg     = arg_q;

    always_comb begin
        o_rdata = '0;
        if (i_addr < `SD_REG_CMD) begin
            o_rdata = arg_q[8*i_addr[1:0] +: 8];
        end else if (i_addr == `SD_REG_CMD) begin
            o_rdata = {2'b00, index_q};
        end else if (i_addr < `SD_REG_RESP_IDX) begin
            o_rdata = resp_arg_q[8*resp_sel[1:0] +: 8];
        end else if (i_addr == `SD_REG_RESP_IDX) begin
            o_rdata = {2'b00, resp_idx_q};
        end else if (i_addr == `SD_REG_STATUS) begin
            o_rdata = {5'b00000, status};
        end
    end

endmodule

//--- rtl/sd_line_arbiter.sv
module sd_line_arbiter import sd_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_cmd_pending,
    input  logic i_tx_done,
    input  logic i_rx_claim,
    input  logic i_rx_release,
    output logic o_grant_tx,
    output logic o_line_free
);

    line_owner_t owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else begin
            case (owner)
                OWN_NONE: begin
                    if (i_cmd_pending) begin      // cpu command beats a start bit
                        owner <= OWN_TX;
                    end else if (i_rx_claim) begin
                        owner <= OWN_RX;
                    end
                end
                OWN_TX: begin
                    if (i_tx_done) begin
                        owner <= OWN_NONE;
                    end
                end
                OWN_RX: begin
                    if (i_rx_release) begin
                        owner <= OWN_NONE;
                    end
                end
                default: begin
                    owner <= OWN_NONE;
                end
            endcase
        end
    end

    assign o_grant_tx  = (owner == OWN_TX);
    // a waiting command keeps the receiver from claiming
    assign o_line_free = (owner == OWN_NONE) && !i_cmd_pending;

endmodule

//--- rtl/sd_pkg.sv
`include "sd_defines.svh"

package sd_pkg;

    // one layout for command and response frames with the msb sent first
    typedef struct packed {
        logic start;                   // always 0
        logic dir;                     // 1 = host to card
        logic [5:0] index;
        logic [`SD_ARG_BITS-1:0] arg;
        logic [6:0] crc;
        logic stop;                    // always 1
    } sd_frame_t;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_TX,
        OWN_RX
    } line_owner_t;

    // read back as status byte bits 2..0
    typedef struct packed {
        logic busy;
        logic resp_valid;
        logic crc_error;
    } sd_status_t;

endpackage

//--- rtl/sd_resp_rx.sv
`include "sd_defines.svh"

module sd_resp_rx import sd_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_line_free,
    input  logic                    i_cmd_bit,
    output logic                    o_claim,
    output logic                    o_release,
    output logic                    o_resp_strobe,
    output logic [5:0]              o_resp_index,
    output logic [`SD_ARG_BITS-1:0] o_resp_arg,
    output logic                    o_resp_crc_ok
);

    localparam logic [5:0] LAST_CAP = 6'(`SD_FRAME_BITS - 2);  // 47 bits after the start bit

    typedef enum logic [1:0] {RX_IDLE, RX_CAPTURE, RX_CHECK} rx_state_t;

    rx_state_t                 state;
    logic [5:0]                bit_cnt;
    logic [`SD_FRAME_BITS-1:0] shreg;
    sd_frame_t                 frame;
    logic                      crc_load;
    logic [6:0]                crc;
    logic                      crc_valid;

    // start bit goes in with the claim so it ends up as bit 47
    always_ff @(posedge clk) begin
        if (o_claim || state == RX_CAPTURE) begin
            shreg <= {shreg[`SD_FRAME_BITS-2:0], i_cmd_bit};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (o_claim) begin
                        state   <= RX_CAPTURE;
                        bit_cnt <= '0;
                    end
                end
                RX_CAPTURE: begin
                    if (bit_cnt == LAST_CAP) begin
                        state <= RX_CHECK;
                    end else begin
                        bit_cnt <= bit_cnt + 6'd1;
                    end
                end
                RX_CHECK: begin
                    if (crc_valid) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // the head is complete before the last bit, so the crc is loaded early
    assign crc_load = (state == RX_CAPTURE) && (bit_cnt == LAST_CAP);

    sd_crc7 u_crc7 (
        .clk     (clk),
        .rst     (rst),
        .i_load  (crc_load),
        .i_data  (shreg[`SD_FRAME_BITS-2 -: `SD_FRAME_BITS-8]),
        .o_crc   (crc),
        .o_valid (crc_valid)
    );

    assign frame         = sd_frame_t'(shreg);
    assign o_claim       = (state == RX_IDLE) && i_line_free && !i_cmd_bit;
    assign o_resp_strobe = (state == RX_CHECK) && crc_valid;
    assign o_release     = o_resp_strobe;
    assign o_resp_index  = frame.index;
    assign o_resp_arg    = frame.arg;
    assign o_resp_crc_ok = (crc == frame.crc) && frame.stop;

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the SD command path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps -f tb.f \
        --top-module tb_sd_cmd_host -Mdir obj_dir -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb.f
+incdir+include
rtl/sd_pkg.sv
rtl/sd_cmd_if.sv
rtl/sd_crc7.sv
rtl/sd_host_regs.sv
rtl/sd_line_arbiter.sv
rtl/sd_cmd_tx.sv
rtl/sd_resp_rx.sv
rtl/sd_cmd_host.sv
testbench/sd_card_model.sv
testbench/tb_sd_cmd_host.sv

//--- testbench/sd_card_model.sv
`include "sd_defines.svh"

module sd_card_model import sd_pkg::*; (
    input  logic                    clk,
    input  logic                    i_host_cmd,
    output logic                    o_cmd,
    input  logic                    i_corrupt,
    input  logic                    i_unsol,
    input  logic [5:0]              i_unsol_index,
    input  logic [`SD_ARG_BITS-1:0] i_unsol_arg,
    output sd_frame_t               o_frame,
    output int                      o_frame_count,
    output int                      o_resp_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESP_GAP = 8;  // idle cycles between command end bit and response

    function automatic logic [6:0] crc7_calc(input logic [39:0] head);
        logic [6:0] c;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            c = {c[5:0], 1'b0} ^ ((head[i] ^ c[6]) ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    function automatic sd_frame_t build_response(input logic [5:0] idx,
                                                 input logic [`SD_ARG_BITS-1:0] arg,
                                                 input logic corrupt);
        sd_frame_t f;
        f.start = 1'b0;
        f.dir   = 1'b0;     // card to host
        f.index = idx;
        f.arg   = arg;
        f.crc   = crc7_calc({f.start, f.dir, f.index, f.arg}) ^ {6'b000000, corrupt};
        f.stop  = 1'b1;
        return f;
    endfunction

    task automatic drive_frame(input sd_frame_t f);
        logic [`SD_FRAME_BITS-1:0] bits;
        bits = f;
        for (int i = `SD_FRAME_BITS - 1; i >= 0; i--) begin
            @(posedge clk);
            o_cmd <= bits[i];
        end
        @(posedge clk);
        o_cmd        <= 1'b1;
        o_resp_count <= o_resp_count + 1;
    endtask

    initial begin
        logic [`SD_FRAME_BITS-1:0] rec;
        sd_frame_t                 f;
        o_cmd         <= 1'b1;
        o_frame       <= '0;
        o_frame_count <= 0;
        o_resp_count  <= 0;
        forever begin
            @(negedge clk);
            if (i_host_cmd === 1'b0) begin
                rec[`SD_FRAME_BITS-1] = 1'b0;  // start bit already seen
                for (int i = `SD_FRAME_BITS - 2; i >= 0; i--) begin
                    @(negedge clk);
                    rec[i] = i_host_cmd;
                end
                f = sd_frame_t'(rec);
                o_frame       <= f;
                o_frame_count <= o_frame_count + 1;
                repeat (RESP_GAP) @(posedge clk);
                drive_frame(build_response(f.index, ~f.arg, i_corrupt));
            end else if (i_unsol) begin
                drive_frame(build_response(i_unsol_index, i_unsol_arg, 1'b0));
            end
        end
    end

endmodule

//--- testbench/tb_sd_cmd_host.sv
`include "sd_defines.svh"

module tb_sd_cmd_host import sd_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 16;
    localparam int RANDOM_CMDS    = 20;
    localparam int TOTAL_CMDS     = RANDOM_CMDS + 4;  // corrupt, unsolicited and the held pair
    localparam int CYCLES_PER_CMD = 200;
    localparam int WAIT_LIMIT     = 200;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cs;
    logic [`SD_ADDR_W-1:0]   addr;
    logic [7:0]              wdata;
    logic [7:0]              rdata;
    logic                    sd_cmd_in;
    logic                    sd_cmd_out;
    logic                    sd_dat_in;
    logic                    sd_dat_out;
    logic                    corrupt;
    logic                    unsol_go;
    logic [5:0]              unsol_index;
    logic [`SD_ARG_BITS-1:0] unsol_arg;
    sd_frame_t               card_frame;
    int                      frame_count;
    int                      resp_count;

    logic [31:0] lfsr = 32'h44448960;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests = 0;
    int          tests_failed = 0;

    always #20 clk = ~clk;

    sd_cmd_host DUT (
        .clk      (clk),
        .rst      (rst),
        .i_cs     (cs),
        .i_addr   (addr),
        .i_wdata  (wdata),
        .o_rdata  (rdata),
        .i_sd_cmd (sd_cmd_in),
        .o_sd_cmd (sd_cmd_out),
        .i_sd_dat (sd_dat_in),
        .o_sd_dat (sd_dat_out)
    );

    sd_card_model card (
        .clk           (clk),
        .i_host_cmd    (sd_cmd_out),
        .o_cmd         (sd_cmd_in),
        .i_corrupt     (corrupt),
        .i_unsol       (unsol_go),
        .i_unsol_index (unsol_index),
        .i_unsol_arg   (unsol_arg),
        .o_frame       (card_frame),
        .o_frame_count (frame_count),
        .o_resp_count  (resp_count)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // expected host frame with crc7 taps at bits 0 and 3
    function automatic sd_frame_t frame_ref(input logic [5:0] idx, input logic [31:0] arg);
        logic [39:0] head;
        logic [6:0]  c;
        logic        fb;
        head = {2'b01, idx, arg};
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = head[i] ^ c[6];
            c = {c[5:3], c[2] ^ fb, c[1:0], fb};
        end
        return sd_frame_t'({head, c, 1'b1});
    endfunction

    task automatic compare_frame(input sd_frame_t got, input sd_frame_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_status(input sd_status_t got, input sd_status_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got busy/valid/crc_err %b expected %b",
                     $time, what, got, exp);
        end
    endtask

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [`SD_ADDR_W-1:0] a, input logic [7:0] d);
        @(posedge clk);
        cs    <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        cs <= 1'b0;
    endtask

    task automatic read_reg(input logic [`SD_ADDR_W-1:0] a, output logic [7:0] d);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        d = rdata;  // read port is combinational
    endtask

    task automatic write_arg(input logic [31:0] arg);
        for (int k = 0; k < 4; k++) begin
            write_reg(`SD_ADDR_W'(k), arg[8*k +: 8]);
        end
    endtask

    task automatic wait_card(input bit on_frames, input int target);
        int n;
        n = 0;
        while ((on_frames ? frame_count : resp_count) < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if ((on_frames ? frame_count : resp_count) < target) begin
            errors++;
            $display("timed out after %0d cycles waiting for the card to %s", WAIT_LIMIT,
                     on_frames ? "record a frame" : "finish a response");
        end else if (!on_frames) begin
            repeat (2) @(posedge clk);  // capture of the end bit and then the strobe
        end
    endtask

    task automatic check_response(input logic [5:0] idx, input logic [31:0] arg,
                                  input sd_status_t st);
        logic [7:0] d;
        for (int k = 0; k < 4; k++) begin
            read_reg(`SD_ADDR_W'(`SD_REG_RESP_ARG + k), d);
            compare_byte(d, arg[8*k +: 8], $sformatf("response byte %0d", k));
        end
        read_reg(`SD_REG_RESP_IDX, d);
        compare_byte(d, {2'b00, idx}, "response index");
        read_reg(`SD_REG_STATUS, d);
        compare_status(sd_status_t'(d[2:0]), st, "status after response");
    endtask

    task automatic run_command(input logic [5:0] idx, input logic [31:0] arg);
        int frames;
        int resps;
        int lat;
        frames = frame_count;
        resps  = resp_count;
        write_arg(arg);
        write_reg(`SD_REG_CMD, {2'b00, idx});
        lat = 1;
        @(negedge clk);
        while (sd_cmd_out && lat < WAIT_LIMIT) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        compare_byte(8'(lat), 8'd4, "cycles from write to start bit");
        wait_card(1'b1, frames + 1);
        compare_frame(card_frame, frame_ref(idx, arg), "sent frame");
        wait_card(1'b0, resps + 1);
        check_response(idx, ~arg, sd_status_t'({1'b0, 1'b1, corrupt}));
    endtask

    task automatic send_unsolicited(input logic [5:0] idx, input logic [31:0] arg);
        @(posedge clk);
        unsol_index <= idx;
        unsol_arg   <= arg;
        unsol_go    <= 1'b1;
        @(posedge clk);
        unsol_go <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: failed", tests, name);
        end else begin
            $display("test %0d %s: ok", tests, name);
        end
        errors_at_start = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] arg;
        logic [5:0]  idx;
        logic [7:0]  d;
        int          lows;
        int          frames;
        int          resps;
        int          n;
        rst         <= 1'b1;
        cs          <= 1'b0;
        addr        <= '0;
        wdata       <= '0;
        sd_dat_in   <= 1'b1;
        corrupt     <= 1'b0;
        unsol_go    <= 1'b0;
        unsol_index <= '0;
        unsol_arg   <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        compare_byte({7'b0000000, sd_cmd_out}, 8'h01, "cmd line after reset");
        compare_byte({7'b0000000, sd_dat_out}, 8'h01, "dat line after reset");
        read_reg(`SD_REG_STATUS, d);
        compare_status(sd_status_t'(d[2:0]), sd_status_t'(3'b000), "status after reset");
        lows = 0;
        repeat (20) begin
            @(negedge clk);
            if (!sd_cmd_out) begin
                lows++;
            end
        end
        compare_byte(8'(lows), 8'd0, "low samples on the idle line");
        finish_test("reset and idle line");

        for (int t = 0; t < RANDOM_CMDS; t++) begin
            take_bits(6, r);
            idx = r[5:0];
            take_bits(32, arg);
            run_command(idx, arg);
            finish_test($sformatf("command %0d index %0d", t, idx));
        end

        take_bits(6, r);
        idx = r[5:0];
        take_bits(32, arg);
        @(posedge clk);
        corrupt <= 1'b1;  // card flips crc bit 0
        run_command(idx, arg);
        @(posedge clk);
        corrupt <= 1'b0;
        finish_test("corrupted response crc");

        take_bits(6, r);
        idx = r[5:0];
        take_bits(32, arg);
        frames = frame_count;
        resps  = resp_count;
        send_unsolicited(idx, arg);
        wait_card(1'b0, resps + 1);
        check_response(idx, arg, sd_status_t'(3'b010));
        compare_byte(8'(frame_count - frames), 8'd0, "frames sent by the host");
        finish_test("unsolicited response");

        take_bits(6, r);
        idx = r[5:0];
        take_bits(32, arg);
        take_bits(32, r);
        frames = frame_count;
        resps  = resp_count;
        send_unsolicited(~idx, r);
        n = 0;
        while (sd_cmd_in && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (sd_cmd_in) begin
            errors++;
            $display("the card did not start its response within %0d cycles", WAIT_LIMIT);
        end
        repeat (4) @(posedge clk);   // land the writes inside the receive
        write_arg(arg);
        write_reg(`SD_REG_CMD, {2'b00, idx});
        write_arg(r);                // dropped while busy
        lows = 0;
        n = 0;
        while (resp_count == resps && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (!sd_cmd_out) begin
                lows++;
            end
            n++;
        end
        compare_byte(8'(lows), 8'd0, "low samples on cmd while the response arrives");
        wait_card(1'b1, frames + 1);
        compare_frame(card_frame, frame_ref(idx, arg), "held frame");
        wait_card(1'b0, resps + 2);
        check_response(idx, ~arg, sd_status_t'(3'b010));
        finish_test("command held during a receive");

        $display("tests %0d, failed %0d, check errors %0d", tests, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + CYCLES_PER_CMD * TOTAL_CMDS) @(posedge clk);
        $display("watchdog expired, the tests did not complete in %0d cycles",
                 RESET_CYCLES + CYCLES_PER_CMD * TOTAL_CMDS);
        $display(">>> FAIL");
        $finish;
    end

endmodule
